// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module ddr_bridge_tb -f project.f \
		--Mdir obj_dir -o ddr_bridge_sim
	./obj_dir/ddr_bridge_sim | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== logic/axi_ram_pkg.sv ====
// widths, address split and beat types shared by the AXI to memory bridge
// the RTL and the testbench both pull their types from here

package axi_ram_pkg;

    // data path
    localparam int DATA_W = 64;
    localparam int STRB_W = DATA_W / 8;

    // byte address and its word address after dropping the byte offset
    localparam int ADDR_W      = 32;
    localparam int LSB         = $clog2(STRB_W);
    localparam int WORD_ADDR_W = ADDR_W - LSB;

    // AXI4 length field, holds beats minus one
    localparam int LEN_W = 8;

    typedef logic [ADDR_W-1:0]      addr_t;
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;
    typedef logic [DATA_W-1:0]      data_t;
    typedef logic [STRB_W-1:0]      strb_t;
    typedef logic [LEN_W-1:0]       len_t;

endpackage

// ==== logic/beat_if.sv ====
// per-word beat from the burst address stage to a read or write data stage
`timescale 1ns/1ps

interface beat_if;
    import axi_ram_pkg::*;

    logic       beat_valid;
    logic       beat_ready;
    word_addr_t beat_addr;
    // high on the final word of a burst
    logic       beat_last;

    modport src (
        output beat_valid,
        input  beat_ready,
        output beat_addr,
        output beat_last
    );

    modport dst (
        input  beat_valid,
        output beat_ready,
        input  beat_addr,
        input  beat_last
    );

endinterface

// ==== logic/burst_addr_gen.sv ====
// splits one incrementing AXI burst request into word addresses, one per beat
// sits behind each AR or AW channel of the bridge
`timescale 1ns/1ps

module burst_addr_gen (
    input  logic               clk,
    input  logic               i_reset,
    input  axi_ram_pkg::addr_t i_req_addr,
    input  axi_ram_pkg::len_t  i_req_len,
    input  logic               i_req_valid,
    output logic               o_req_ready,
    beat_if.src                beat
);
    import axi_ram_pkg::*;

    logic       active_q;
    word_addr_t addr_q;
    len_t       left_q;
    logic       req_fire;
    logic       beat_fire;

    assign req_fire  = i_req_valid & o_req_ready;
    assign beat_fire = beat.beat_valid & beat.beat_ready;

    // the current beat is simply the burst state
    assign beat.beat_valid = active_q;
    assign beat.beat_addr  = addr_q;
    assign beat.beat_last  = (left_q == '0);

    // burst FSM, ready comes up one edge after reset and whenever idle
    always_ff @(posedge clk) begin
        if (i_reset) begin
            active_q    <= 1'b0;
            o_req_ready <= 1'b0;
        end else if (req_fire) begin
            active_q    <= 1'b1;
            o_req_ready <= 1'b0;
        end else if (beat_fire && beat.beat_last) begin
            active_q    <= 1'b0;
            o_req_ready <= 1'b1;
        end else if (!active_q) begin
            o_req_ready <= 1'b1;
        end
    end

    // word address and remaining beat count
    always_ff @(posedge clk) begin
        if (req_fire) begin
            addr_q <= i_req_addr[ADDR_W-1:LSB];
            left_q <= i_req_len;
        end else if (beat_fire) begin
            addr_q <= addr_q + 1'b1;
            left_q <= left_q - 1'b1;
        end
    end

    // bursts start on a full word
    assert property (@(posedge clk) disable iff (i_reset)
        i_req_valid |-> (i_req_addr[LSB-1:0] == '0))
        else $error("unaligned burst address %h", i_req_addr);

    // a stalled beat keeps its address and last flag
    assert property (@(posedge clk) disable iff (i_reset)
        (beat.beat_valid && !beat.beat_ready) |=>
            (beat.beat_valid && $stable(beat.beat_addr) && $stable(beat.beat_last)))
        else $error("beat payload changed while stalled");

endmodule

// ==== logic/ddr_bridge_top.sv ====
// AXI4 burst to memory port bridge standing in for DDR in accelerator simulation
// pixel and weights read channels plus the output write channel, all independent
`timescale 1ns/1ps

module ddr_bridge_top (
    input  logic                    clk,
    input  logic                    i_reset,

    // pixel read channel
    input  axi_ram_pkg::addr_t      i_pix_araddr,
    input  axi_ram_pkg::len_t       i_pix_arlen,
    input  logic                    i_pix_arvalid,
    output logic                    o_pix_arready,
    output axi_ram_pkg::data_t      o_pix_rdata,
    output logic                    o_pix_rlast,
    output logic                    o_pix_rvalid,
    input  logic                    i_pix_rready,
    output logic                    o_pix_rd,
    output axi_ram_pkg::word_addr_t o_pix_raddr,
    input  axi_ram_pkg::data_t      i_pix_mem_rdata,

    // weights read channel
    input  axi_ram_pkg::addr_t      i_wgt_araddr,
    input  axi_ram_pkg::len_t       i_wgt_arlen,
    input  logic                    i_wgt_arvalid,
    output logic                    o_wgt_arready,
    output axi_ram_pkg::data_t      o_wgt_rdata,
    output logic                    o_wgt_rlast,
    output logic                    o_wgt_rvalid,
    input  logic                    i_wgt_rready,
    output logic                    o_wgt_rd,
    output axi_ram_pkg::word_addr_t o_wgt_raddr,
    input  axi_ram_pkg::data_t      i_wgt_mem_rdata,

    // output write channel
    input  axi_ram_pkg::addr_t      i_out_awaddr,
    input  axi_ram_pkg::len_t       i_out_awlen,
    input  logic                    i_out_awvalid,
    output logic                    o_out_awready,
    input  axi_ram_pkg::data_t      i_out_wdata,
    input  axi_ram_pkg::strb_t      i_out_wstrb,
    input  logic                    i_out_wlast,
    input  logic                    i_out_wvalid,
    output logic                    o_out_wready,
    output logic                    o_out_bvalid,
    input  logic                    i_out_bready,
    output logic                    o_out_we,
    output axi_ram_pkg::word_addr_t o_out_waddr,
    output axi_ram_pkg::data_t      o_out_mem_wdata,
    output axi_ram_pkg::strb_t      o_out_mem_wstrb
);

    beat_if pix_beat ();
    beat_if wgt_beat ();
    beat_if out_beat ();

    // pixel reads
    burst_addr_gen u_pix_ar (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_req_addr  (i_pix_araddr),
        .i_req_len   (i_pix_arlen),
        .i_req_valid (i_pix_arvalid),
        .o_req_ready (o_pix_arready),
        .beat        (pix_beat.src)
    );

    read_data_stage u_pix_r (
        .clk      (clk),
        .i_reset  (i_reset),
        .beat     (pix_beat.dst),
        .o_rd     (o_pix_rd),
        .o_raddr  (o_pix_raddr),
        .i_rdata  (i_pix_mem_rdata),
        .o_rdata  (o_pix_rdata),
        .o_rlast  (o_pix_rlast),
        .o_rvalid (o_pix_rvalid),
        .i_rready (i_pix_rready)
    );

    // weights reads
    burst_addr_gen u_wgt_ar (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_req_addr  (i_wgt_araddr),
        .i_req_len   (i_wgt_arlen),
        .i_req_valid (i_wgt_arvalid),
        .o_req_ready (o_wgt_arready),
        .beat        (wgt_beat.src)
    );

    read_data_stage u_wgt_r (
        .clk      (clk),
        .i_reset  (i_reset),
        .beat     (wgt_beat.dst),
        .o_rd     (o_wgt_rd),
        .o_raddr  (o_wgt_raddr),
        .i_rdata  (i_wgt_mem_rdata),
        .o_rdata  (o_wgt_rdata),
        .o_rlast  (o_wgt_rlast),
        .o_rvalid (o_wgt_rvalid),
        .i_rready (i_wgt_rready)
    );

    // output writes
    burst_addr_gen u_out_aw (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_req_addr  (i_out_awaddr),
        .i_req_len   (i_out_awlen),
        .i_req_valid (i_out_awvalid),
        .o_req_ready (o_out_awready),
        .beat        (out_beat.src)
    );

    write_data_stage u_out_w (
        .clk      (clk),
        .i_reset  (i_reset),
        .beat     (out_beat.dst),
        .i_wdata  (i_out_wdata),
        .i_wstrb  (i_out_wstrb),
        .i_wlast  (i_out_wlast),
        .i_wvalid (i_out_wvalid),
        .o_wready (o_out_wready),
        .o_we     (o_out_we),
        .o_waddr  (o_out_waddr),
        .o_wdata  (o_out_mem_wdata),
        .o_wstrb  (o_out_mem_wstrb),
        .o_bvalid (o_out_bvalid),
        .i_bready (i_out_bready)
    );

endmodule

// ==== logic/read_data_stage.sv ====
// turns beats into single-cycle memory reads and streams the words out as AXI R
// a two-entry skid keeps reads at full rate while rready is low
`timescale 1ns/1ps

module read_data_stage (
    input  logic                    clk,
    input  logic                    i_reset,
    beat_if.dst                     beat,
    output logic                    o_rd,
    output axi_ram_pkg::word_addr_t o_raddr,
    input  axi_ram_pkg::data_t      i_rdata,
    output axi_ram_pkg::data_t      o_rdata,
    output logic                    o_rlast,
    output logic                    o_rvalid,
    input  logic                    i_rready
);
    import axi_ram_pkg::*;

    logic       pend_q;
    logic       pend_last_q;
    data_t      skid_data_q [2];
    logic [1:0] skid_last_q;
    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic [1:0] count_q;
    logic       push;
    logic       pop;
    logic [1:0] held;

    // words held = one in flight from memory plus the skid contents
    assign held = count_q + {1'b0, pend_q};
    assign push = pend_q;
    assign pop  = o_rvalid & i_rready;

    // take a beat only if room remains after this cycle's pop
    assign beat.beat_ready = (held - {1'b0, pop}) < 2'd2;

    // memory read goes out in the beat handshake cycle
    assign o_rd    = beat.beat_valid & beat.beat_ready;
    assign o_raddr = beat.beat_addr;

    assign o_rvalid = (count_q != 2'd0);
    assign o_rdata  = skid_data_q[rd_ptr_q];
    assign o_rlast  = skid_last_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            pend_q   <= 1'b0;
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            pend_q  <= o_rd;
            count_q <= count_q + {1'b0, push} - {1'b0, pop};
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
        end
    end

    // last flag rides along with the read, memory word lands a cycle later
    always_ff @(posedge clk) begin
        if (o_rd) begin
            pend_last_q <= beat.beat_last;
        end
        if (push) begin
            skid_data_q[wr_ptr_q] <= i_rdata;
            skid_last_q[wr_ptr_q] <= pend_last_q;
        end
    end

    // never more than two words between the memory and the reader
    assert property (@(posedge clk) disable iff (i_reset)
        held <= 2'd2)
        else $error("read skid overflow, %0d words held", held);

endmodule

// ==== logic/write_data_stage.sv ====
// pairs write beats with AXI W data into registered memory writes
// one B response goes out after the final word of each burst
`timescale 1ns/1ps

module write_data_stage (
    input  logic                    clk,
    input  logic                    i_reset,
    beat_if.dst                     beat,
    input  axi_ram_pkg::data_t      i_wdata,
    input  axi_ram_pkg::strb_t      i_wstrb,
    input  logic                    i_wlast,
    input  logic                    i_wvalid,
    output logic                    o_wready,
    output logic                    o_we,
    output axi_ram_pkg::word_addr_t o_waddr,
    output axi_ram_pkg::data_t      o_wdata,
    output axi_ram_pkg::strb_t      o_wstrb,
    output logic                    o_bvalid,
    input  logic                    i_bready
);
    import axi_ram_pkg::*;

    logic we_last_q;
    logic stall;
    logic fire;

    // hold off beats from the final write until B is taken
    assign stall = o_bvalid | we_last_q;

    // beat and W move together
    assign o_wready        = beat.beat_valid & ~stall;
    assign beat.beat_ready = i_wvalid & ~stall;
    assign fire            = beat.beat_valid & i_wvalid & ~stall;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_we      <= 1'b0;
            we_last_q <= 1'b0;
            o_bvalid  <= 1'b0;
        end else begin
            o_we      <= fire;
            we_last_q <= fire & beat.beat_last;
            // response one edge after the last write pulse
            if (we_last_q) begin
                o_bvalid <= 1'b1;
            end else if (i_bready) begin
                o_bvalid <= 1'b0;
            end
        end
    end

    // memory write payload
    always_ff @(posedge clk) begin
        if (fire) begin
            o_waddr <= beat.beat_addr;
            o_wdata <= i_wdata;
            o_wstrb <= i_wstrb;
        end
    end

    // the writer's wlast must land on the burst's final address
    assert property (@(posedge clk) disable iff (i_reset)
        fire |-> (i_wlast == beat.beat_last))
        else $error("wlast %b disagrees with beat_last %b", i_wlast, beat.beat_last);

endmodule

// ==== project.f ====
logic/axi_ram_pkg.sv
logic/beat_if.sv
logic/burst_addr_gen.sv
logic/read_data_stage.sv
logic/write_data_stage.sv
logic/ddr_bridge_top.sv
tb/ddr_bridge_checker.sv
tb/ddr_bridge_tb.sv

// ==== tb/ddr_bridge_checker.sv ====
// watches every DUT port and checks reads, writes and responses against a model
// the model memory word for an address is shared with the testbench read memories
`timescale 1ns/1ps

module ddr_bridge_checker (
    input logic clk, i_reset,
    input axi_ram_pkg::addr_t i_pix_araddr, i_wgt_araddr, i_out_awaddr,
    input axi_ram_pkg::len_t i_pix_arlen, i_wgt_arlen, i_out_awlen,
    input logic i_pix_arvalid, o_pix_arready, i_wgt_arvalid, o_wgt_arready,
    input axi_ram_pkg::data_t o_pix_rdata, o_wgt_rdata, i_out_wdata, o_out_mem_wdata,
    input logic o_pix_rlast, o_pix_rvalid, i_pix_rready, o_pix_rd,
    input logic o_wgt_rlast, o_wgt_rvalid, i_wgt_rready, o_wgt_rd,
    input axi_ram_pkg::word_addr_t o_pix_raddr, o_wgt_raddr, o_out_waddr,
    input logic i_out_awvalid, o_out_awready, i_out_wlast, i_out_wvalid, o_out_wready,
    input axi_ram_pkg::strb_t i_out_wstrb, o_out_mem_wstrb,
    input logic o_out_bvalid, i_out_bready, o_out_we
);
    import axi_ram_pkg::*;

    int         value_errors = 0;
    int         other_errors = 0;
    word_addr_t rd_exp [2][$];
    word_addr_t r_exp [2][$];
    logic       r_last_exp [2][$];
    int         words_issued [2] = '{0, 0};
    int         words_seen [2] = '{0, 0};
    word_addr_t aw_exp [$];
    logic       aw_last_exp [$];
    word_addr_t we_addr_q [$];
    data_t      we_data_q [$];
    strb_t      we_strb_q [$];
    logic       we_last_q [$];
    data_t      exp_mem [word_addr_t];
    int         bursts_closed = 0;
    int         b_seen = 0;
    logic       reset_d = 1'b0;

    // read memory contents depend on the whole word address in every bit
    function automatic data_t model_word(word_addr_t a);
        return {a ^ 29'h15a5_a5a5, 6'h2c, a};
    endfunction

    task automatic value_error(string name, logic [63:0] exp, logic [63:0] act);
        $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
        value_errors++;
    endtask

    task automatic other_error(string msg);
        $display("%0t %s", $time, msg);
        other_errors++;
    endtask

    task automatic expect_low(string name, logic v);
        if (v !== 1'b0) value_error(name, 64'd0, 64'(v));
    endtask

    task automatic read_channel(int ch, string tag, logic ar_fire, addr_t araddr, len_t arlen,
                                logic rd, word_addr_t raddr, logic r_fire, data_t rdata,
                                logic rlast);
        word_addr_t a;
        if (rd) begin
            if (rd_exp[ch].size() == 0) begin
                other_error({tag, " memory read issued with no burst pending"});
            end else begin
                a = rd_exp[ch].pop_front();
                if (raddr !== a) value_error({tag, "_raddr"}, 64'(a), 64'(raddr));
            end
        end
        if (r_fire) begin
            if (r_exp[ch].size() == 0) begin
                other_error({tag, " returned a word that no burst asked for"});
            end else begin
                a = r_exp[ch].pop_front();
                if (rdata !== model_word(a)) value_error({tag, "_rdata"}, model_word(a), rdata);
                if (rlast !== r_last_exp[ch][0]) begin
                    value_error({tag, "_rlast"}, 64'(r_last_exp[ch][0]), 64'(rlast));
                end
                void'(r_last_exp[ch].pop_front());
                words_seen[ch]++;
            end
        end
        if (ar_fire) begin
            for (int k = 0; k <= int'(arlen); k++) begin
                a = araddr[ADDR_W-1:LSB] + word_addr_t'(k);
                rd_exp[ch].push_back(a);
                r_exp[ch].push_back(a);
                r_last_exp[ch].push_back(k == int'(arlen));
            end
            words_issued[ch] += int'(arlen) + 1;
        end
    endtask

    always @(posedge clk) begin
        word_addr_t a;
        data_t      d;
        // state seen here was set by a reset edge
        if (reset_d) begin
            expect_low("o_pix_rvalid", o_pix_rvalid);
            expect_low("o_wgt_rvalid", o_wgt_rvalid);
            expect_low("o_out_bvalid", o_out_bvalid);
            expect_low("o_pix_rd", o_pix_rd);
            expect_low("o_wgt_rd", o_wgt_rd);
            expect_low("o_out_we", o_out_we);
            expect_low("o_pix_arready", o_pix_arready);
            expect_low("o_wgt_arready", o_wgt_arready);
            expect_low("o_out_awready", o_out_awready);
            expect_low("o_out_wready", o_out_wready);
        end
        reset_d <= i_reset;
        if (!i_reset) begin
            read_channel(0, "o_pix", i_pix_arvalid & o_pix_arready, i_pix_araddr, i_pix_arlen,
                         o_pix_rd, o_pix_raddr, o_pix_rvalid & i_pix_rready, o_pix_rdata,
                         o_pix_rlast);
            read_channel(1, "o_wgt", i_wgt_arvalid & o_wgt_arready, i_wgt_araddr, i_wgt_arlen,
                         o_wgt_rd, o_wgt_raddr, o_wgt_rvalid & i_wgt_rready, o_wgt_rdata,
                         o_wgt_rlast);
            // memory write from a W beat taken one edge earlier
            if (o_out_we) begin
                if (we_addr_q.size() == 0) begin
                    other_error("output memory written with no write data taken");
                end else begin
                    a = we_addr_q.pop_front();
                    d = we_data_q.pop_front();
                    if (o_out_waddr !== a) value_error("o_out_waddr", 64'(a), 64'(o_out_waddr));
                    if (o_out_mem_wdata !== d) value_error("o_out_mem_wdata", d, o_out_mem_wdata);
                    if (o_out_mem_wstrb !== we_strb_q[0]) begin
                        value_error("o_out_mem_wstrb", 64'(we_strb_q[0]), 64'(o_out_mem_wstrb));
                    end
                    for (int b = 0; b < STRB_W; b++) begin
                        if (!exp_mem.exists(a)) exp_mem[a] = '0;
                        if (we_strb_q[0][b]) exp_mem[a][8*b +: 8] = d[8*b +: 8];
                    end
                    void'(we_strb_q.pop_front());
                    if (we_last_q.pop_front()) bursts_closed++;
                end
            end
            if (o_out_bvalid && i_out_bready) begin
                if (b_seen >= bursts_closed) other_error("write response before the burst ended");
                b_seen++;
            end
            if (i_out_wvalid && o_out_wready) begin
                if (aw_exp.size() == 0) begin
                    other_error("write data accepted with no burst address");
                end else begin
                    we_addr_q.push_back(aw_exp.pop_front());
                    we_data_q.push_back(i_out_wdata);
                    we_strb_q.push_back(i_out_wstrb);
                    we_last_q.push_back(aw_last_exp[0]);
                    if (i_out_wlast !== aw_last_exp[0]) begin
                        value_error("i_out_wlast", 64'(aw_last_exp[0]), 64'(i_out_wlast));
                    end
                    void'(aw_last_exp.pop_front());
                end
            end
            if (i_out_awvalid && o_out_awready) begin
                for (int k = 0; k <= int'(i_out_awlen); k++) begin
                    aw_exp.push_back(i_out_awaddr[ADDR_W-1:LSB] + word_addr_t'(k));
                    aw_last_exp.push_back(k == int'(i_out_awlen));
                end
            end
        end
    end

    // nothing left in flight on any channel
    function automatic logic drained();
        return rd_exp[0].size() == 0 && r_exp[0].size() == 0 && rd_exp[1].size() == 0 &&
               r_exp[1].size() == 0 && aw_exp.size() == 0 && we_addr_q.size() == 0 &&
               b_seen == bursts_closed;
    endfunction

    task automatic check_mem(word_addr_t a, data_t d);
        if (!exp_mem.exists(a)) other_error("output memory holds a word that was never written");
        else if (d !== exp_mem[a]) value_error("out_mem", exp_mem[a], d);
    endtask

    task automatic report(input int mem_words, input int b_expected, output int total);
        if (mem_words != exp_mem.num()) other_error("output memory word count differs");
        for (int ch = 0; ch < 2; ch++) begin
            if (words_seen[ch] != words_issued[ch]) other_error("read word total differs");
        end
        if (b_seen != b_expected) other_error("write response total differs");
        $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        total = value_errors + other_errors;
    endtask

endmodule

// ==== tb/ddr_bridge_tb.sv ====
// testbench for the AXI burst to memory bridge with random bursts and throttling
// read memories and the output memory are modeled here and a checker module compares
`timescale 1ns/1ps

module ddr_bridge_tb;
    import axi_ram_pkg::*;

    localparam int NBURST = 24;
    localparam int SEED   = 11;

    logic clk, i_reset;
    addr_t i_pix_araddr, i_wgt_araddr, i_out_awaddr;
    len_t i_pix_arlen, i_wgt_arlen, i_out_awlen;
    logic i_pix_arvalid, o_pix_arready, i_wgt_arvalid, o_wgt_arready;
    data_t o_pix_rdata, o_wgt_rdata, i_out_wdata, o_out_mem_wdata;
    data_t i_pix_mem_rdata, i_wgt_mem_rdata;
    logic o_pix_rlast, o_pix_rvalid, i_pix_rready, o_pix_rd;
    logic o_wgt_rlast, o_wgt_rvalid, i_wgt_rready, o_wgt_rd;
    word_addr_t o_pix_raddr, o_wgt_raddr, o_out_waddr;
    logic i_out_awvalid, o_out_awready, i_out_wlast, i_out_wvalid, o_out_wready;
    strb_t i_out_wstrb, o_out_mem_wstrb;
    logic o_out_bvalid, i_out_bready, o_out_we;

    data_t       out_mem [word_addr_t];
    logic [31:0] lcg_state;
    len_t        w_len_q [$];
    int          pix_sent, wgt_sent, out_sent, w_beat, b_got, errors;
    logic        pix_hit, wgt_hit, pix_ar_fire, wgt_ar_fire, aw_fire, w_fire, b_fire;
    word_addr_t  pix_a, wgt_a;

    ddr_bridge_top UUT (.*);
    ddr_bridge_checker u_checker (.*);

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;
    endfunction

    // a full data word from three draws of 24 random bits
    function automatic data_t rand_data();
        data_t w;
        w = '0;
        for (int i = 0; i < 3; i++) begin
            w = (w << 24) | data_t'(next_rand());
        end
        return w;
    endfunction

    // valid or ready is let through on about three cycles in four
    function automatic logic allow();
        return (next_rand() % 32'd4) != 32'd0;
    endfunction

    function automatic addr_t burst_addr(addr_t base);
        return base + (next_rand() % 32'd256) * 32'd8;
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (NBURST * 40) @(posedge clk);
        $display("watchdog expired before all bursts completed");
        $display("TESTS FAILED");
        $finish;
    end

    // read memories answer one cycle after the read strobe
    always @(posedge clk) begin
        pix_hit = o_pix_rd;
        pix_a   = o_pix_raddr;
        wgt_hit = o_wgt_rd;
        wgt_a   = o_wgt_raddr;
        #1;
        if (pix_hit) i_pix_mem_rdata = u_checker.model_word(pix_a);
        if (wgt_hit) i_wgt_mem_rdata = u_checker.model_word(wgt_a);
    end

    always @(posedge clk) begin
        if (o_out_we) begin
            if (!out_mem.exists(o_out_waddr)) out_mem[o_out_waddr] = '0;
            for (int b = 0; b < STRB_W; b++) begin
                if (o_out_mem_wstrb[b]) out_mem[o_out_waddr][8*b +: 8] = o_out_mem_wdata[8*b +: 8];
            end
        end
    end

    initial begin
        lcg_state = SEED;
        i_reset = 1'b1;
        {i_pix_araddr, i_pix_arlen, i_pix_arvalid, i_pix_rready, i_pix_mem_rdata} = '0;
        {i_wgt_araddr, i_wgt_arlen, i_wgt_arvalid, i_wgt_rready, i_wgt_mem_rdata} = '0;
        {i_out_awaddr, i_out_awlen, i_out_awvalid, i_out_bready} = '0;
        {i_out_wdata, i_out_wstrb, i_out_wlast, i_out_wvalid} = '0;
        {pix_sent, wgt_sent, out_sent, w_beat, b_got} = '0;
        repeat (4) @(posedge clk);
        #1 i_reset = 1'b0;
        while (!(pix_sent == NBURST && wgt_sent == NBURST && b_got == NBURST &&
                 u_checker.drained())) begin
            @(posedge clk);
            pix_ar_fire = i_pix_arvalid & o_pix_arready;
            wgt_ar_fire = i_wgt_arvalid & o_wgt_arready;
            aw_fire     = i_out_awvalid & o_out_awready;
            w_fire      = i_out_wvalid & o_out_wready;
            b_fire      = o_out_bvalid & i_out_bready;
            #1;
            if (pix_ar_fire) begin
                i_pix_arvalid = 1'b0;
                pix_sent++;
            end
            if (!i_pix_arvalid && pix_sent < NBURST && allow()) begin
                i_pix_araddr  = burst_addr(32'h0001_0000);
                i_pix_arlen   = len_t'(next_rand() % 32'd16);
                i_pix_arvalid = 1'b1;
            end
            i_pix_rready = allow();
            if (wgt_ar_fire) begin
                i_wgt_arvalid = 1'b0;
                wgt_sent++;
            end
            if (!i_wgt_arvalid && wgt_sent < NBURST && allow()) begin
                i_wgt_araddr  = burst_addr(32'h0002_0000);
                i_wgt_arlen   = len_t'(next_rand() % 32'd16);
                i_wgt_arvalid = 1'b1;
            end
            i_wgt_rready = allow();
            if (aw_fire) begin
                i_out_awvalid = 1'b0;
                out_sent++;
            end
            if (!i_out_awvalid && out_sent < NBURST && allow()) begin
                i_out_awaddr  = burst_addr(32'h0004_0000);
                i_out_awlen   = len_t'(next_rand() % 32'd16);
                i_out_awvalid = 1'b1;
                w_len_q.push_back(i_out_awlen);
            end
            // W beats follow the bursts in address order
            if (w_fire) begin
                i_out_wvalid = 1'b0;
                if (i_out_wlast) begin
                    void'(w_len_q.pop_front());
                    w_beat = 0;
                end else begin
                    w_beat++;
                end
            end
            if (!i_out_wvalid && w_len_q.size() > 0 && allow()) begin
                i_out_wdata  = rand_data();
                i_out_wstrb  = strb_t'(next_rand());
                i_out_wlast  = (w_beat == int'(w_len_q[0]));
                i_out_wvalid = 1'b1;
            end
            if (b_fire) b_got++;
            i_out_bready = allow();
        end
        repeat (4) @(posedge clk);
        foreach (out_mem[a]) u_checker.check_mem(a, out_mem[a]);
        u_checker.report(out_mem.num(), NBURST, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
